/* Bender.yml */
package:
  name: uart_link

sources:
  - uart_link_pkg.sv
  - uart_frame_tx.sv
  - uart_frame_rx.sv
  - uart_link.sv
  - target: test
    files:
      - uart_link_monitor.sv
      - uart_link_chk.sv
      - tb_uart_link.sv

/* tb_uart_link.sv */
module tb_uart_link
   import uart_link_pkg::*;
();

   localparam int clks_per_bit = 4;
   localparam int period       = 20;

   typedef struct packed {
      logic [7:0]  kind;   // L for loopback, F for an injected frame.
      logic [15:0] word;   // Command, or the raw frame in the low 11 bits.
      logic [7:0]  exp_hi;
      logic [7:0]  exp_lo;
      logic        parity_err;
      logic        frame_err;
   } test_rec_t;

   logic        clk = 1'b0;
   logic        rst_n;
   cmd_word_t   cmd;
   logic        cmd_vld;
   logic        cmd_rdy;
   logic        tx;
   logic        rx = 1'b1;
   logic        read_rdy;
   rx_result_t  read_res;
   logic        loop_en;
   logic        rx_inj;
   logic        loaded = 1'b0;
   logic [31:0] rng = 32'hb8d6_9740;
   int unsigned tb_errors  = 0;
   int unsigned n_commands = 0;
   test_rec_t   recs[$];

   uart_link #(.clks_per_bit(clks_per_bit)) i_uart_link (.*);

   uart_link_monitor #(.clks_per_bit(clks_per_bit)) i_monitor (.*);

   bind uart_link uart_link_chk i_uart_link_chk (.*);

   always #(period / 2) clk = ~clk;

   always @(posedge clk) begin
      rx <= loop_en ? tx : rx_inj;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   //**************************************************************************
   // Data file
   //**************************************************************************

   task automatic load_records();
      int          fd;
      int          n;
      int          pe;
      int          fe;
      logic [15:0] w;
      logic [7:0]  hi;
      logic [7:0]  lo;
      string       line;
      test_rec_t   r;
      fd = $fopen("uart_link_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the data file uart_link_input.txt");
         tb_errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         r = '0;
         n = 0;
         pe = 0;
         fe = 0;
         lo = '0;
         r.kind = line.getc(0);
         if (r.kind == "L") begin
            n = $sscanf(line, "L %h %h %h", w, hi, lo) + 1;
         end else if (r.kind == "F") begin
            n = $sscanf(line, "F %b %h %d %d", w, hi, pe, fe);
         end
         if (n == 4) begin
            r.word       = w;
            r.exp_hi     = hi;
            r.exp_lo     = lo;
            r.parity_err = pe[0];
            r.frame_err  = fe[0];
            recs.push_back(r);
         end else if (r.kind == "L" || r.kind == "F") begin
            $display("Malformed record in the data file: %s", line);
            tb_errors++;
         end
      end
      $fclose(fd);
      if (recs.size() == 0) begin
         $display("The data file holds no test records");
         tb_errors++;
      end
   endtask

   //**************************************************************************
   // Stimulus
   //**************************************************************************

   task automatic send_command(input test_rec_t r);
      loop_en <= 1'b1;
      i_monitor.push_expected(r.exp_hi, 1'b0, 1'b0);
      i_monitor.push_expected(r.exp_lo, 1'b0, 1'b0);
      cmd     <= r.word;
      cmd_vld <= 1'b1;
      @(posedge clk);
      while (!cmd_rdy) begin
         @(posedge clk);
      end
      cmd <= ~r.word; // Held valid while busy, so this word must never go out.
      repeat (3 * clks_per_bit) @(posedge clk);
      cmd_vld <= 1'b0;
      n_commands++;
   endtask

   task automatic inject_frame(input test_rec_t r);
      i_monitor.push_expected(r.exp_hi, r.parity_err, r.frame_err);
      loop_en <= 1'b0;
      for (int i = frame_bits - 1; i >= 0; i--) begin
         rx_inj <= r.word[i];
         repeat (clks_per_bit) @(posedge clk);
      end
      rx_inj <= 1'b1;
   endtask

   task automatic report_and_finish();
      int unsigned asserts;
      asserts = i_uart_link.i_uart_link_chk.fails;
      $display("Errors: %0d value mismatches, %0d assertion failures, %0d other failures",
               i_monitor.value_errors, asserts, i_monitor.other_errors + tb_errors);
      if (i_monitor.value_errors + i_monitor.other_errors + tb_errors + asserts == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   initial begin
      rst_n   = 1'b0;
      cmd     = '0;
      cmd_vld = 1'b0;
      loop_en = 1'b0;
      rx_inj  = 1'b1;
      load_records();
      loaded = 1'b1;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      foreach (recs[i]) begin
         rng = next_random(rng);
         repeat (rng[2:0]) @(posedge clk); // Idle gap of 0 to 7 cycles.
         if (recs[i].kind == "L") begin
            send_command(recs[i]);
         end else begin
            inject_frame(recs[i]);
         end
         while (i_monitor.pending_count() != 0) begin
            @(posedge clk);
         end
      end
      repeat (4 * clks_per_bit) @(posedge clk);
      i_monitor.check_totals(n_commands);
      report_and_finish();
   end

   // Each record takes at most about 24 bit periods; the rest is margin.
   initial begin : watchdog
      longint limit;
      wait (loaded);
      limit = (longint'(recs.size()) * (24 * clks_per_bit + 16) + 116) * period;
      #(limit);
      $display("Timeout: the run did not finish within %0d time units", limit);
      tb_errors++;
      report_and_finish();
   end

endmodule

/* uart_frame_rx.sv */
module uart_frame_rx
   import uart_link_pkg::*;
#(
   parameter int clks_per_bit = 4
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx,
   output logic       read_rdy,
   output rx_result_t read_res
);

   localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam int half  = clks_per_bit / 2;

   logic             rx_meta;
   logic             rx_sync;
   logic             rx_d;
   logic             busy;
   logic [cnt_w-1:0] clk_cnt;
   logic [3:0]       bit_cnt;
   logic             start_edge;
   logic             active;
   logic             sample;
   logic             last_cnt;
   logic             glitch;
   logic             frame_done;
   uart_frame_u      frame_q;
   uart_frame_u      frame_next;

   //**************************************************************************
   // Input synchronizer
   //**************************************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_d    <= 1'b1; // Previous value for the edge detect.
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_d    <= rx_sync;
      end
   end

   //**************************************************************************
   // Frame timing
   //**************************************************************************

   // The detect cycle is the first cycle of the start bit, so it counts as index 0.
   assign start_edge = !busy && rx_d && !rx_sync;
   assign active     = busy || start_edge;
   assign sample     = active && (clk_cnt == cnt_w'(half));
   assign last_cnt   = (clk_cnt == cnt_w'(clks_per_bit - 1));
   assign glitch     = sample && (bit_cnt == 4'd0) && rx_sync;
   assign frame_done = sample && (bit_cnt == 4'(frame_bits - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         clk_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         if (glitch || frame_done) begin
            busy <= 1'b0;
         end else if (start_edge) begin
            busy <= 1'b1;
         end

         if (!active || glitch || frame_done || last_cnt) begin
            clk_cnt <= '0;
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
         end

         if (glitch || frame_done) begin
            bit_cnt <= '0;
         end else if (sample) begin
            bit_cnt <= bit_cnt + 4'd1;
         end
      end
   end

   //**************************************************************************
   // Frame assembly and checks
   //**************************************************************************

   assign frame_next.bits = {frame_q.bits[frame_bits-2:0], rx_sync};

   always_ff @(posedge clk) begin
      if (sample) begin
         frame_q <= frame_next;
      end
   end

   // The result is taken from the frame as it completes, on the stop sample.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_rdy <= 1'b0;
         read_res <= '0;
      end else begin
         read_rdy <= frame_done;
         if (frame_done) begin
            read_res.data       <= frame_next.fields.data;
            read_res.parity_err <= frame_next.fields.parity !=
                                   odd_parity(frame_next.fields.data);
            read_res.frame_err  <= !frame_next.fields.stop;
         end
      end
   end

endmodule

/* uart_frame_tx.sv */
module uart_frame_tx
   import uart_link_pkg::*;
#(
   parameter int clks_per_bit = 4
) (
   input  logic      clk,
   input  logic      rst_n,
   input  cmd_word_t cmd,
   input  logic      cmd_vld,
   output logic      cmd_rdy,
   output logic      tx
);

   localparam int cnt_w     = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam int link_bits = 2 * frame_bits;

   uart_frame_u          hi_frame;
   uart_frame_u          lo_frame;
   logic [link_bits-1:0] shift_q;
   logic [cnt_w-1:0]     clk_cnt;
   logic [4:0]           bit_cnt;
   logic                 accept;
   logic                 bit_end;
   logic                 last_bit;

   //**************************************************************************
   // Frame build
   //**************************************************************************

   always_comb begin
      hi_frame.fields = '{
         start:  1'b0,
         data:   cmd.hi,
         parity: odd_parity(cmd.hi),
         stop:   1'b1
      };
      lo_frame.fields = '{
         start:  1'b0,
         data:   cmd.lo,
         parity: odd_parity(cmd.lo),
         stop:   1'b1
      };
   end

   assign accept   = cmd_vld && cmd_rdy;
   assign bit_end  = (clk_cnt == cnt_w'(clks_per_bit - 1));
   assign last_bit = (bit_cnt == 5'(link_bits - 1));

   //**************************************************************************
   // Bit timing
   //**************************************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         clk_cnt <= '0;
         bit_cnt <= '0;
         cmd_rdy <= 1'b1;
      end else if (accept) begin
         clk_cnt <= '0;
         bit_cnt <= '0;
         cmd_rdy <= 1'b0;
      end else if (!cmd_rdy) begin
         if (bit_end) begin
            clk_cnt <= '0;
            if (last_bit) begin
               bit_cnt <= '0;
               cmd_rdy <= 1'b1; // Stop bit of the lo frame has ended.
            end else begin
               bit_cnt <= bit_cnt + 5'd1;
            end
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   // Ones fill in behind the data, so the line is back to idle when done.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         shift_q <= '1;
      end else if (accept) begin
         shift_q <= {hi_frame.bits, lo_frame.bits};
      end else if (!cmd_rdy && bit_end) begin
         shift_q <= {shift_q[link_bits-2:0], 1'b1};
      end
   end

   assign tx = shift_q[link_bits-1];

endmodule

/* uart_link.f */
uart_link_pkg.sv
uart_frame_tx.sv
uart_frame_rx.sv
uart_link.sv
uart_link_monitor.sv
uart_link_chk.sv
tb_uart_link.sv

/* uart_link.sv */
module uart_link
   import uart_link_pkg::*;
#(
   parameter int clks_per_bit = 4 // Clock cycles per serial bit. It must be at least 1.
) (
   input  logic       clk,
   input  logic       rst_n,
   input  cmd_word_t  cmd,
   input  logic       cmd_vld,
   output logic       cmd_rdy,
   output logic       tx,
   input  logic       rx,
   output logic       read_rdy,
   output rx_result_t read_res
);

   //**************************************************************************
   // Transmit path
   //**************************************************************************

   // Sends each accepted command as two frames, hi byte first.
   uart_frame_tx #(
      .clks_per_bit(clks_per_bit)
   ) i_uart_frame_tx (
      .clk    (clk),
      .rst_n  (rst_n),
      .cmd    (cmd),
      .cmd_vld(cmd_vld),
      .cmd_rdy(cmd_rdy),
      .tx     (tx)
   );

   //**************************************************************************
   // Receive path
   //**************************************************************************

   uart_frame_rx #(
      .clks_per_bit(clks_per_bit)
   ) i_uart_frame_rx (
      .clk     (clk),
      .rst_n   (rst_n),
      .rx      (rx),
      .read_rdy(read_rdy),
      .read_res(read_res)
   );

endmodule

/* uart_link_chk.sv */
module uart_link_chk (
   input logic clk,
   input logic rst_n,
   input logic cmd_vld,
   input logic cmd_rdy,
   input logic tx,
   input logic read_rdy
);

   int unsigned fails = 0;

   rdy_drops: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_vld && cmd_rdy |=> !cmd_rdy)
   else begin
      $error("cmd_rdy stayed high after a command was accepted");
      fails++;
   end

   // The line idles high whenever the transmitter is free.
   idle_line: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
   else begin
      $error("tx is low while cmd_rdy is high");
      fails++;
   end

   single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      read_rdy |=> !read_rdy)
   else begin
      $error("read_rdy was high on two cycles in a row");
      fails++;
   end

   no_unknown: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown({cmd_rdy, tx, read_rdy}))
   else begin
      $error("A control output is unknown after reset");
      fails++;
   end

endmodule

/* uart_link_input.txt */
# L <command hex> <expected hi byte> <expected lo byte>
# F <11 frame bits, start bit first> <expected byte> <parity_err> <frame_err>
L 1234 12 34
F 01010010111 a5 0 0
L a5c3 a5 c3
F 00011110001 3c 1 0
L 00ff 00 ff
F 01000000110 81 0 1
L ff00 ff 00
F 00000000000 00 1 1
L 8001 80 01
F 01111111111 ff 0 0
L 7e7e 7e 7e
F 00000000111 01 1 0
L 5aa5 5a a5

/* uart_link_monitor.sv */
module uart_link_monitor
   import uart_link_pkg::*;
#(
   parameter int clks_per_bit = 4
) (
   input logic       clk,
   input logic       rst_n,
   input logic       cmd_vld,
   input logic       cmd_rdy,
   input logic       tx,
   input logic       read_rdy,
   input rx_result_t read_res
);

   rx_result_t  exp_q[$];
   int unsigned value_errors = 0;
   int unsigned other_errors = 0;
   int unsigned accepted     = 0;
   int unsigned tx_frames    = 0;

   task automatic push_expected(input logic [7:0] data, input logic parity_err,
                                input logic frame_err);
      exp_q.push_back({data, parity_err, frame_err});
   endtask

   function automatic int pending_count();
      return exp_q.size();
   endfunction

   // The odd parity bit is set when the byte holds an even number of ones.
   function automatic logic parity_for(input logic [7:0] data);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         ones += data[i];
      end
      return (ones % 2) == 0;
   endfunction

   task automatic compare_field(input string name, input logic [7:0] exp_v,
                                input logic [7:0] act_v);
      if (exp_v !== act_v) begin
         $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                  $time, name, exp_v, act_v);
         value_errors++;
      end
   endtask

   always @(posedge clk) begin
      if (rst_n && cmd_vld && cmd_rdy) begin
         accepted++;
      end
   end

   always @(posedge clk) begin : check_rx
      rx_result_t exp_r;
      if (rst_n && read_rdy) begin
         if (exp_q.size() == 0) begin
            $display("read_rdy pulsed at time %0t with no result expected", $time);
            other_errors++;
         end else begin
            exp_r = exp_q.pop_front();
            compare_field("read_res.data", exp_r.data, read_res.data);
            compare_field("read_res.parity_err", 8'(exp_r.parity_err),
                          8'(read_res.parity_err));
            compare_field("read_res.frame_err", 8'(exp_r.frame_err),
                          8'(read_res.frame_err));
         end
      end
   end

   //**************************************************************************
   // Transmit line sampler
   //**************************************************************************

   always begin : watch_tx
      logic [frame_bits-1:0] bits;
      @(posedge clk);
      if (rst_n && tx === 1'b0) begin
         repeat (clks_per_bit / 2) @(posedge clk); // Middle of the start bit.
         for (int i = 0; i < frame_bits; i++) begin
            bits = {bits[frame_bits-2:0], tx};
            if (i < frame_bits - 1) begin
               repeat (clks_per_bit) @(posedge clk);
            end
         end
         tx_frames++;
         compare_field("tx parity bit", 8'(parity_for(bits[9:2])), 8'(bits[1]));
         compare_field("tx stop bit", 8'd1, 8'(bits[0]));
      end
   end

   task automatic check_totals(input int unsigned commands);
      if (exp_q.size() != 0) begin
         $display("%0d expected receive results never arrived", exp_q.size());
         other_errors++;
      end
      if (accepted != commands || tx_frames != 2 * accepted) begin
         $display("Handshake counts are off: %0d commands sent, %0d accepted, %0d frames",
                  commands, accepted, tx_frames);
         other_errors++;
      end
   endtask

endmodule

/* uart_link_pkg.sv */
package uart_link_pkg;

   //**************************************************************************
   // Frame format
   //**************************************************************************

   localparam int frame_bits = 11; // Start, eight data bits, parity, stop.

   // Fields in the order they appear on the line, so the MSB goes out first.
   typedef struct packed {
      logic       start;
      logic [7:0] data;
      logic       parity;
      logic       stop;
   } uart_frame_t;

   // The transmitter shifts the raw bits and the receiver checks the fields.
   typedef union packed {
      uart_frame_t           fields;
      logic [frame_bits-1:0] bits;
   } uart_frame_u;

   //**************************************************************************
   // Command and receive words
   //**************************************************************************

   typedef struct packed {
      logic [7:0] hi; // Sent first.
      logic [7:0] lo;
   } cmd_word_t;

   typedef struct packed {
      logic [7:0] data;
      logic       parity_err;
      logic       frame_err; // Stop bit read as 0.
   } rx_result_t;

   // Parity bit that gives data plus parity an odd number of ones.
   function automatic logic odd_parity(input logic [7:0] data);
      return ~^data;
   endfunction

endpackage
